/* axi_fifo_bridge.sv */
module axi_fifo_bridge import fifo_bridge_pkg::*; (
    input  logic      s_axi_aclk,
    input  logic      s_axi_aresetn,
    // AW channel
    input  axi_addr_t s_axi_awaddr,
    input  axi_id_t   s_axi_awid,
    input  logic      s_axi_awvalid,
    output logic      s_axi_awready,
    // W channel
    input  axi_data_t s_axi_wdata,
    input  logic      s_axi_wvalid,
    input  logic      s_axi_wlast,
    output logic      s_axi_wready,
    // B channel
    input  logic      s_axi_bready,
    output logic      s_axi_bvalid,
    output axi_resp_t s_axi_bresp,
    output axi_id_t   s_axi_bid,
    // Signal-generation core
    output axi_data_t core_fifo_din,
    output logic      core_fifo_write,
    output logic      core_flush,
    input  logic      core_full,
    output logic      dac_mode,
    output logic      core_reset
);

    // Beat strobes
    logic      fifo_beat;
    logic      flush_beat;
    logic      dac_beat;
    axi_data_t beat_data;
    // Response path
    logic      resp_req;
    logic      resp_err;
    axi_id_t   resp_id;
    logic      resp_done;

    //////////////////////////////
    // Write controller
    //////////////////////////////

    axi_write_ctrl u_write_ctrl (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .awaddr        (s_axi_awaddr),
        .awid          (s_axi_awid),
        .awvalid       (s_axi_awvalid),
        .awready       (s_axi_awready),
        .wdata         (s_axi_wdata),
        .wvalid        (s_axi_wvalid),
        .wlast         (s_axi_wlast),
        .wready        (s_axi_wready),
        .core_full     (core_full),
        .fifo_beat     (fifo_beat),
        .flush_beat    (flush_beat),
        .dac_beat      (dac_beat),
        .beat_data     (beat_data),
        .resp_req      (resp_req),
        .resp_err      (resp_err),
        .resp_id       (resp_id),
        .resp_done     (resp_done)
    );

    //////////////////////////////
    // Core outputs and B channel
    //////////////////////////////

    core_port u_core_port (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .fifo_beat     (fifo_beat),
        .flush_beat    (flush_beat),
        .dac_beat      (dac_beat),
        .beat_data     (beat_data),
        .fifo_din      (core_fifo_din),
        .fifo_write    (core_fifo_write),
        .flush         (core_flush),
        .dac_mode      (dac_mode),
        .core_reset    (core_reset)
    );

    bresp_gen u_bresp_gen (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .resp_req      (resp_req),
        .resp_err      (resp_err),
        .resp_id       (resp_id),
        .bvalid        (s_axi_bvalid),
        .bresp         (s_axi_bresp),
        .bid           (s_axi_bid),
        .bready        (s_axi_bready),
        .resp_done     (resp_done)
    );

endmodule

/* axi_write_ctrl.sv */
`include "fifo_bridge_config.svh"

module axi_write_ctrl import fifo_bridge_pkg::*; (
    input  logic      s_axi_aclk,
    input  logic      s_axi_aresetn,
    // AW channel
    input  axi_addr_t awaddr,
    input  axi_id_t   awid,
    input  logic      awvalid,
    output logic      awready,
    // W channel
    input  axi_data_t wdata,
    input  logic      wvalid,
    input  logic      wlast,
    output logic      wready,
    // Core back-pressure
    input  logic      core_full,
    // Beat strobes toward core_port
    output logic      fifo_beat,
    output logic      flush_beat,
    output logic      dac_beat,
    output axi_data_t beat_data,
    // Response request toward bresp_gen
    output logic      resp_req,
    output logic      resp_err,
    output axi_id_t   resp_id,
    input  logic      resp_done
);

    wr_state_t state;
    wr_state_t aw_target;
    logic      aw_xfer;
    logic      w_xfer;

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    // AW only taken between transactions
    assign awready = (state == W_IDLE);
    assign aw_xfer = awvalid && awready;

    always_comb begin
        case (state)
            // Stall FIFO beats while the core is full
            W_FIFO: wready = !core_full;
            // Other targets never stall
            W_FLUSH, W_DAC, W_DROP: wready = 1'b1;
            default: wready = 1'b0;
        endcase
    end

    assign w_xfer = wvalid && wready;

    // Address decode, unknown addresses go to discard
    always_comb begin
        case (awaddr)
            `BRIDGE_ADDR_FIFO: aw_target = W_FIFO;
            `BRIDGE_ADDR_FLUSH: aw_target = W_FLUSH;
            `BRIDGE_ADDR_DAC: aw_target = W_DAC;
            default: aw_target = W_DROP;
        endcase
    end

    //////////////////////////////
    // Write FSM
    //////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    if (aw_xfer) begin
                        state <= aw_target;
                    end
                end
                W_FIFO, W_FLUSH, W_DAC, W_DROP: begin
                    // Burst ends on wlast, AW length not tracked
                    if (w_xfer && wlast) begin
                        state <= W_RESP;
                    end
                end
                W_RESP: begin
                    // Hold off AW until the B transfer
                    if (resp_done) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // Per-target beat strobes, same cycle as the W transfer
    assign fifo_beat  = w_xfer && (state == W_FIFO);
    assign flush_beat = w_xfer && (state == W_FLUSH);
    assign dac_beat   = w_xfer && (state == W_DAC);
    assign beat_data  = wdata;

    //////////////////////////////
    // Response request
    //////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            resp_req <= 1'b0;
        end else begin
            resp_req <= w_xfer && wlast;
        end
    end

    // Id and error flag captured with AW, stable through W_RESP
    always_ff @(posedge s_axi_aclk) begin
        if (aw_xfer) begin
            resp_id  <= awid;
            resp_err <= (aw_target == W_DROP);
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_one_strobe: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        $onehot0({fifo_beat, flush_beat, dac_beat}));

    // A beat never lands once the burst has closed
    a_strobe_state: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (fifo_beat || flush_beat || dac_beat) |-> !$past(w_xfer && wlast));

    a_ready_excl: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(awready && wready));

endmodule

/* bresp_gen.sv */
`include "fifo_bridge_config.svh"

module bresp_gen import fifo_bridge_pkg::*; (
    input  logic      s_axi_aclk,
    input  logic      s_axi_aresetn,
    // Request from the write controller
    input  logic      resp_req,
    input  logic      resp_err,
    input  axi_id_t   resp_id,
    // B channel
    output logic      bvalid,
    output axi_resp_t bresp,
    output axi_id_t   bid,
    input  logic      bready,
    // Completion back to the controller
    output logic      resp_done
);

    //////////////////////////////
    // B channel register
    //////////////////////////////

    // Assert first, drop after the cycle with bready
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            bvalid <= 1'b0;
        end else if (resp_req) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // Code and id only change on a new request
    always_ff @(posedge s_axi_aclk) begin
        if (resp_req) begin
            bresp <= resp_err ? `BRIDGE_RESP_SLVERR : `BRIDGE_RESP_OKAY;
            bid   <= resp_id;
        end
    end

    assign resp_done = bvalid && bready;

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (bvalid && !bready) |=> (bvalid && $stable(bresp) && $stable(bid)));

endmodule

/* bridge_vectors.txt */
# name addr(hex) id(hex) beats resp(0 okay, 2 slverr)
# then one hex data word per beat, on the same or following lines
fifo_single 00 0001 1 0
  0123456789abcdef0011223344556677
fifo_burst4 00 1234 4 0
  fedcba98765432100f0e0d0c0b0a0908 a5a5a5a55a5a5a5a0000ffff1111eeee
  00000000000000000000000000000001 80000000000000000000000000000000
flush_mixed 10 0042 3 0 1 0 3
dac_set 20 0007 2 0 0 1
bad_addr_08 08 beef 2 2 ff 1
fifo_burst3 00 00ff 3 0
  13579bdf02468ace13579bdf02468ace 0000000100000002000000030000000f
  deadbeefcafef00d0123012301230123
dac_clear 20 0100 1 0 2
bad_addr_3f 3f 0abc 1 2 1
flush_none 10 0003 2 0 0 2
dac_set_again 20 7fff 1 0 5

/* core_port.sv */
module core_port import fifo_bridge_pkg::*; (
    input  logic      s_axi_aclk,
    input  logic      s_axi_aresetn,
    // Beat strobes from the write controller
    input  logic      fifo_beat,
    input  logic      flush_beat,
    input  logic      dac_beat,
    input  axi_data_t beat_data,
    // Core side
    output axi_data_t fifo_din,
    output logic      fifo_write,
    output logic      flush,
    output logic      dac_mode,
    output logic      core_reset
);

    //////////////////////////////
    // FIFO push
    //////////////////////////////

    // Word only loaded on an accepted beat
    always_ff @(posedge s_axi_aclk) begin
        if (fifo_beat) begin
            fifo_din <= beat_data;
        end
    end

    // One write pulse per beat, aligned with fifo_din
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            fifo_write <= 1'b0;
        end else begin
            fifo_write <= fifo_beat;
        end
    end

    //////////////////////////////
    // Flush and DAC mode
    //////////////////////////////

    // Pulse per flush beat with bit 0 set
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            flush <= 1'b0;
        end else begin
            flush <= flush_beat && beat_data[0];
        end
    end

    // Level follows bit 0, both set and clear
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            dac_mode <= 1'b0;
        end else if (dac_beat) begin
            dac_mode <= beat_data[0];
        end
    end

    //////////////////////////////
    // Core reset
    //////////////////////////////

    // Registered copy of the inverted bus reset
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= 1'b0;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_write_flush_excl: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(fifo_write && flush));

    a_core_reset: assert property (@(posedge s_axi_aclk)
        !s_axi_aresetn |=> core_reset);

endmodule

/* fifo_bridge_config.svh */
`ifndef FIFO_BRIDGE_CONFIG_SVH
`define FIFO_BRIDGE_CONFIG_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// AW address, wide enough for the three targets
`define BRIDGE_ADDR_W 6
// One W beat maps to one core FIFO word
`define BRIDGE_DATA_W 128
`define BRIDGE_ID_W 16

//////////////////////////////
// Write target map
//////////////////////////////

`define BRIDGE_ADDR_FIFO 6'h00
`define BRIDGE_ADDR_FLUSH 6'h10
`define BRIDGE_ADDR_DAC 6'h20

// B channel codes
`define BRIDGE_RESP_OKAY 2'd0
`define BRIDGE_RESP_SLVERR 2'd2

`endif

/* fifo_bridge_pkg.sv */
`include "fifo_bridge_config.svh"

package fifo_bridge_pkg;

    //////////////////////////////
    // Bus field types
    //////////////////////////////

    typedef logic [`BRIDGE_ADDR_W-1:0] axi_addr_t;
    // Also the core FIFO word
    typedef logic [`BRIDGE_DATA_W-1:0] axi_data_t;
    typedef logic [`BRIDGE_ID_W-1:0] axi_id_t;
    typedef logic [1:0] axi_resp_t;

    //////////////////////////////
    // Write FSM
    //////////////////////////////

    // One beat state per target, plus discard and response wait
    typedef enum logic [2:0] {
        W_IDLE,
        W_FIFO,
        W_FLUSH,
        W_DAC,
        W_DROP,
        W_RESP
    } wr_state_t;

endpackage

/* tb.f */
+incdir+.
fifo_bridge_pkg.sv
axi_write_ctrl.sv
core_port.sv
bresp_gen.sv
axi_fifo_bridge.sv
tb_checker.sv
tb_axi_fifo_bridge.sv

/* tb_axi_fifo_bridge.sv */
`include "fifo_bridge_config.svh"

module tb_axi_fifo_bridge import fifo_bridge_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic      s_axi_aclk;
    logic      s_axi_aresetn;
    axi_addr_t awaddr;
    axi_id_t   awid;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    logic      wvalid;
    logic      wlast;
    logic      wready;
    logic      bready;
    logic      bvalid;
    axi_resp_t bresp;
    axi_id_t   bid;
    axi_data_t fifo_din;
    logic      fifo_write;
    logic      flush;
    logic      core_full;
    logic      dac_mode;
    logic      core_reset;

    // Vector table, beat data of all tests in one queue
    string     names[$];
    axi_addr_t addrs[$];
    axi_id_t   ids[$];
    int        beats[$];
    axi_resp_t resps[$];
    axi_data_t words[$];

    integer    seed = 32'h06ef_0589;
    int        cycles = 0;
    int        cycle_limit = 0;
    logic      full_on = 1'b0;
    // DAC level as the address map predicts it
    logic      dac_exp = 1'b0;

    axi_fifo_bridge u_dut (
        .s_axi_aclk      (s_axi_aclk),
        .s_axi_aresetn   (s_axi_aresetn),
        .s_axi_awaddr    (awaddr),
        .s_axi_awid      (awid),
        .s_axi_awvalid   (awvalid),
        .s_axi_awready   (awready),
        .s_axi_wdata     (wdata),
        .s_axi_wvalid    (wvalid),
        .s_axi_wlast     (wlast),
        .s_axi_wready    (wready),
        .s_axi_bready    (bready),
        .s_axi_bvalid    (bvalid),
        .s_axi_bresp     (bresp),
        .s_axi_bid       (bid),
        .core_fifo_din   (fifo_din),
        .core_fifo_write (fifo_write),
        .core_flush      (flush),
        .core_full       (core_full),
        .dac_mode        (dac_mode),
        .core_reset      (core_reset)
    );

    tb_checker u_chk (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .awvalid       (awvalid),
        .awready       (awready),
        .wvalid        (wvalid),
        .wready        (wready),
        .wlast         (wlast),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .bid           (bid),
        .fifo_din      (fifo_din),
        .fifo_write    (fifo_write),
        .flush         (flush),
        .core_full     (core_full),
        .dac_mode      (dac_mode),
        .core_reset    (core_reset)
    );

    initial begin
        s_axi_aclk = 1'b0;
        forever #2 s_axi_aclk = ~s_axi_aclk;
    end

    // Run limit, set once the vectors are known
    always @(posedge s_axi_aclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Driver
    //////////////////////////////

    // One edge, core_full re-rolled only during FIFO tests
    task automatic tick();
        @(posedge s_axi_aclk);
        if (full_on) begin
            core_full <= ($random(seed) & 1) != 0;
        end else begin
            core_full <= 1'b0;
        end
    endtask

    // Columns: name addr id beats resp, then the data words
    task automatic load_vectors(output bit ok);
        int        fd;
        int        n;
        int        nb;
        int        k;
        int        r;
        string     tok;
        logic [8*160-1:0] rest;
        axi_addr_t a;
        axi_id_t   i;
        axi_data_t w;
        fd = $fopen("bridge_vectors.txt", "r");
        ok = (fd != 0);
        while (ok && $fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h %d %d", a, i, nb, r);
                ok = (n == 4);
                names.push_back(tok);
                addrs.push_back(a);
                ids.push_back(i);
                beats.push_back(nb);
                resps.push_back(r[1:0]);
                for (k = 0; k < nb; k++) begin
                    n = $fscanf(fd, "%h", w);
                    words.push_back(w);
                end
                cycle_limit += 40 * nb;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t, input int base);
        int        flushes;
        int        gap;
        int        k;
        axi_data_t w;
        flushes = 0;
        // Expected core activity from the address map
        for (k = 0; k < beats[t]; k++) begin
            w = words[base + k];
            case (addrs[t])
                `BRIDGE_ADDR_FIFO: u_chk.push_word(w);
                `BRIDGE_ADDR_FLUSH: flushes += w[0];
                `BRIDGE_ADDR_DAC: dac_exp = w[0];
                default: ;
            endcase
        end
        u_chk.expect_test(names[t], ids[t], resps[t],
            (addrs[t] == `BRIDGE_ADDR_FIFO) ? beats[t] : 0, flushes, dac_exp);
        full_on = (addrs[t] == `BRIDGE_ADDR_FIFO);
        awaddr  <= addrs[t];
        awid    <= ids[t];
        awvalid <= 1'b1;
        do tick(); while (!awready);
        awvalid <= 1'b0;
        // W beats with random idle gaps
        for (k = 0; k < beats[t]; k++) begin
            gap = $random(seed) & 3;
            if (gap > 0) begin
                wvalid <= 1'b0;
                repeat (gap) tick();
            end
            wvalid <= 1'b1;
            wdata  <= words[base + k];
            wlast  <= (k == beats[t] - 1);
            do tick(); while (!wready);
        end
        wvalid  <= 1'b0;
        wlast   <= 1'b0;
        full_on = 1'b0;
        // bready held back a random number of cycles
        do tick(); while (!bvalid);
        repeat ($random(seed) & 3) tick();
        bready <= 1'b1;
        tick();
        bready <= 1'b0;
    endtask

    initial begin
        bit ok;
        int base;
        int t;
        s_axi_aresetn = 1'b0;
        awaddr    = '0;
        awid      = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        wlast     = 1'b0;
        bready    = 1'b0;
        core_full = 1'b0;
        load_vectors(ok);
        cycle_limit += 64;
        if (!ok || names.size() == 0) begin
            $display("Could not read the test vectors from bridge_vectors.txt");
            $display("TEST FAIL");
        end else begin
            repeat (10) tick();
            s_axi_aresetn <= 1'b1;
            tick();
            base = 0;
            for (t = 0; t < names.size(); t++) begin
                run_test(t, base);
                base += beats[t];
            end
            repeat (4) tick();
            u_chk.print_counts();
            if (u_chk.errors == 0 && u_chk.done_count == names.size()) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
        end
        $finish;
    end

endmodule

/* tb_checker.sv */
`include "fifo_bridge_config.svh"

module tb_checker import fifo_bridge_pkg::*; (
    input logic      s_axi_aclk,
    input logic      s_axi_aresetn,
    input logic      awvalid,
    input logic      awready,
    input logic      wvalid,
    input logic      wready,
    input logic      wlast,
    input logic      bvalid,
    input logic      bready,
    input axi_resp_t bresp,
    input axi_id_t   bid,
    input axi_data_t fifo_din,
    input logic      fifo_write,
    input logic      flush,
    input logic      core_full,
    input logic      dac_mode,
    input logic      core_reset
);

    timeunit 1ns;
    timeprecision 1ps;

    // Expected tests in issue order, retired by B transfers
    string     exp_name[$];
    axi_id_t   exp_id[$];
    axi_resp_t exp_resp[$];
    int        exp_writes[$];
    int        exp_flushes[$];
    logic      exp_dac[$];
    axi_data_t exp_words[$];

    int        errors = 0;
    int        done_count = 0;
    int        pass_count = 0;
    int        test_errors = 0;
    int        write_cnt = 0;
    int        flush_cnt = 0;
    int        cyc = 0;
    int        wlast_cyc = 0;
    // AW open between transactions only
    logic      aw_exp = 1'b1;
    // Oldest outstanding test targets the FIFO
    logic      fifo_test = 1'b0;
    // Values seen on the previous edge
    logic      rstn_q = 1'b0;
    logic      beat_q = 1'b0;
    logic      bvalid_q = 1'b0;
    logic      bready_q = 1'b0;
    axi_resp_t bresp_q;
    axi_id_t   bid_q;

    task automatic push_word(input axi_data_t w);
        exp_words.push_back(w);
    endtask

    task automatic expect_test(input string name, input axi_id_t id, input axi_resp_t resp,
                               input int writes, input int flushes, input logic dac);
        exp_name.push_back(name);
        exp_id.push_back(id);
        exp_resp.push_back(resp);
        exp_writes.push_back(writes);
        exp_flushes.push_back(flushes);
        exp_dac.push_back(dac);
    endtask

    task automatic mismatch(input string what, input logic [127:0] exp, input logic [127:0] act);
        $display("Fail %s: %s expected %0h actual %0h",
            (exp_name.size() > 0) ? exp_name[0] : "idle", what, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("Error: %s", msg);
        errors++;
        test_errors++;
    endtask

    // Close the oldest test on its B transfer
    task automatic retire_test();
        if (exp_name.size() == 0) begin
            protocol_error("B response with no write outstanding");
        end else begin
            if (bresp !== exp_resp[0]) mismatch("bresp", exp_resp[0], bresp);
            if (bid !== exp_id[0]) mismatch("bid", exp_id[0], bid);
            if (write_cnt != exp_writes[0]) mismatch("fifo_write count", exp_writes[0], write_cnt);
            if (flush_cnt != exp_flushes[0]) mismatch("flush count", exp_flushes[0], flush_cnt);
            if (dac_mode !== exp_dac[0]) mismatch("dac_mode", exp_dac[0], dac_mode);
            if (test_errors == 0) begin
                $display("%s: ok", exp_name[0]);
                pass_count++;
            end else begin
                $display("%s: %0d errors", exp_name[0], test_errors);
            end
            done_count++;
            exp_name.delete(0);
            exp_id.delete(0);
            exp_resp.delete(0);
            exp_writes.delete(0);
            exp_flushes.delete(0);
            exp_dac.delete(0);
        end
        test_errors = 0;
        write_cnt   = 0;
        flush_cnt   = 0;
    endtask

    task automatic print_counts();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
            done_count, pass_count, done_count - pass_count, errors);
    endtask

    //////////////////////////////
    // Per-edge monitor
    //////////////////////////////

    always @(posedge s_axi_aclk) begin
        fifo_test = exp_writes.size() > 0 && exp_writes[0] > 0;
        if (cyc > 0 && !rstn_q) begin
            // Reset values one edge into reset
            if (core_reset !== 1'b1 || bvalid !== 1'b0 || fifo_write !== 1'b0 || flush !== 1'b0)
                protocol_error("outputs not in their reset state during bus reset");
        end else if (cyc > 0) begin
            if (core_reset !== 1'b0) protocol_error("core_reset still high after reset release");
            // AW closed from its transfer until the cycle after the B transfer
            if (awready !== aw_exp) mismatch("awready", aw_exp, awready);
            if (awvalid && awready) aw_exp = 1'b0;
            // Core full holds off FIFO beats
            if (fifo_test && core_full === 1'b1 && wvalid && wready)
                protocol_error("FIFO beat accepted while core_full was high");
            // FIFO write exactly one cycle after each accepted FIFO beat
            if (fifo_write !== beat_q) mismatch("fifo_write", beat_q, fifo_write);
            if (fifo_write === 1'b1) begin
                write_cnt++;
                if (exp_words.size() == 0) begin
                    protocol_error("FIFO write with no data expected");
                end else begin
                    if (fifo_din !== exp_words[0]) mismatch("fifo_din", exp_words[0], fifo_din);
                    exp_words.delete(0);
                end
            end
            if (flush === 1'b1) flush_cnt++;
            if (wvalid && wready && wlast) wlast_cyc = cyc;
            if (bvalid && !bvalid_q && cyc - wlast_cyc != 2)
                mismatch("bvalid delay after wlast", 2, cyc - wlast_cyc);
            if (bvalid_q && !bready_q && (bvalid !== 1'b1 || bresp !== bresp_q || bid !== bid_q))
                protocol_error("B channel dropped or changed before bready");
            if (bvalid && bready) begin
                retire_test();
                aw_exp = 1'b1;
            end
        end
        beat_q   = wvalid && wready && exp_writes.size() > 0 && exp_writes[0] > 0;
        rstn_q   = s_axi_aresetn;
        bvalid_q = bvalid;
        bready_q = bready;
        bresp_q  = bresp;
        bid_q    = bid;
        cyc++;
    end

endmodule
